//--- verilog.f
+incdir+hw
hw/rv_pkg.sv
hw/fetch_buffer.sv
hw/control_unit.sv
hw/int_regfile.sv
hw/fp_regfile.sv
hw/instr_decode.sv
hw/execute.sv
hw/core_top.sv
tb/clk_gen.sv
tb/core_checker.sv
tb/core_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module core_tb -o core_tb_sim \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation ended with an error, see sim.log"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- tb/core_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module core_tb;
    typedef struct packed {
        rv_pkg::word_t    instr;
        rv_pkg::reg_idx_t rd;
        logic             fp;
        rv_pkg::word_t    result;
        logic             illegal;
        logic [3:0]       group;
    } row_t;

    logic clk;
    logic reset;
    logic in_valid;
    rv_pkg::word_t in_instr;
    logic in_credit;
    logic retire_valid;
    rv_pkg::reg_idx_t retire_rd;
    logic retire_fp;
    rv_pkg::word_t retire_result;
    logic retire_illegal;

    row_t rows[$];
    logic [31:0] lcg_state = 32'hdac55cac;
    int credits;
    int ret_idx = 0;
    int errors = 0;
    int group_errors = 0;
    int groups_passed = 0;
    int groups_failed = 0;

    clk_gen u_clk_gen (
        .clk(clk),
        .reset(reset)
    );

    core_top DUT (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_credit(in_credit),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_fp(retire_fp),
        .retire_result(retire_result),
        .retire_illegal(retire_illegal)
    );

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                            input int f3, input int rd, input logic [6:0] opc);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t enc_i(input int imm, input int rs1, input int f3,
                                            input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic rv_pkg::word_t enc_u(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1: return "integer alu";
            2: return "immediates";
            3: return "fp register file";
            4: return "dependent sequences";
            5: return "credits and ordering";
            default: return "illegal encodings";
        endcase
    endfunction

    task automatic add_row(input rv_pkg::word_t instr, input int rd, input logic fp,
                           input rv_pkg::word_t result, input logic illegal, input int group);
        row_t r;
        r.instr = instr;
        r.rd = rd[4:0];
        r.fp = fp;
        r.result = result;
        r.illegal = illegal;
        r.group = group[3:0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(enc_i(100, 0, 0, 1, `OPC_OP_IMM), 1, 1'b0, 32'h00000064, 1'b0, 1);
        add_row(enc_i(-7, 0, 0, 2, `OPC_OP_IMM), 2, 1'b0, 32'hfffffff9, 1'b0, 1);
        // write to x0 retires but must not stick
        add_row(enc_r(7'h00, 1, 1, 0, 0, `OPC_OP), 0, 1'b0, 32'h000000c8, 1'b0, 1);
        add_row(enc_r(7'h00, 2, 1, 0, 3, `OPC_OP), 3, 1'b0, 32'h0000005d, 1'b0, 1);
        add_row(enc_r(7'h20, 2, 1, 0, 4, `OPC_OP), 4, 1'b0, 32'h0000006b, 1'b0, 1);
        add_row(enc_r(7'h00, 2, 1, 7, 5, `OPC_OP), 5, 1'b0, 32'h00000060, 1'b0, 1);
        add_row(enc_r(7'h00, 2, 1, 6, 6, `OPC_OP), 6, 1'b0, 32'hfffffffd, 1'b0, 1);
        add_row(enc_r(7'h00, 2, 1, 4, 7, `OPC_OP), 7, 1'b0, 32'hffffff9d, 1'b0, 1);
        add_row(enc_r(7'h00, 1, 2, 2, 8, `OPC_OP), 8, 1'b0, 32'h00000001, 1'b0, 1);
        add_row(enc_r(7'h00, 2, 1, 2, 9, `OPC_OP), 9, 1'b0, 32'h00000000, 1'b0, 1);
        add_row(enc_r(7'h00, 1, 0, 0, 10, `OPC_OP), 10, 1'b0, 32'h00000064, 1'b0, 1);
        add_row(enc_i(-1, 1, 0, 11, `OPC_OP_IMM), 11, 1'b0, 32'h00000063, 1'b0, 2);
        add_row(enc_i(240, 2, 7, 12, `OPC_OP_IMM), 12, 1'b0, 32'h000000f0, 1'b0, 2);
        add_row(enc_i(-2048, 1, 6, 13, `OPC_OP_IMM), 13, 1'b0, 32'hfffff864, 1'b0, 2);
        add_row(enc_i(-1, 2, 4, 14, `OPC_OP_IMM), 14, 1'b0, 32'h00000006, 1'b0, 2);
        add_row(enc_u(32'habcde, 15, `OPC_LUI), 15, 1'b0, 32'habcde000, 1'b0, 2);
        add_row(enc_r(7'h78, 0, 15, 0, 0, `OPC_OP_FP), 0, 1'b1, 32'habcde000, 1'b0, 3);
        add_row(enc_r(7'h78, 0, 1, 0, 1, `OPC_OP_FP), 1, 1'b1, 32'h00000064, 1'b0, 3);
        add_row(enc_r(7'h10, 0, 1, 0, 2, `OPC_OP_FP), 2, 1'b1, 32'h80000064, 1'b0, 3);
        add_row(enc_r(7'h10, 0, 0, 1, 3, `OPC_OP_FP), 3, 1'b1, 32'h2bcde000, 1'b0, 3);
        add_row(enc_r(7'h10, 0, 2, 2, 4, `OPC_OP_FP), 4, 1'b1, 32'h00000064, 1'b0, 3);
        add_row(enc_r(7'h70, 0, 0, 0, 16, `OPC_OP_FP), 16, 1'b0, 32'habcde000, 1'b0, 3);
        add_row(enc_r(7'h70, 0, 2, 0, 17, `OPC_OP_FP), 17, 1'b0, 32'h80000064, 1'b0, 3);
        add_row(enc_i(5, 0, 0, 18, `OPC_OP_IMM), 18, 1'b0, 32'h00000005, 1'b0, 4);
        add_row(enc_i(5, 18, 0, 18, `OPC_OP_IMM), 18, 1'b0, 32'h0000000a, 1'b0, 4);
        add_row(enc_i(5, 18, 0, 18, `OPC_OP_IMM), 18, 1'b0, 32'h0000000f, 1'b0, 4);
        add_row(enc_i(-20, 18, 0, 18, `OPC_OP_IMM), 18, 1'b0, 32'hfffffffb, 1'b0, 4);
        add_row(enc_r(7'h78, 0, 18, 0, 5, `OPC_OP_FP), 5, 1'b1, 32'hfffffffb, 1'b0, 4);
        add_row(enc_r(7'h10, 1, 5, 0, 6, `OPC_OP_FP), 6, 1'b1, 32'h7ffffffb, 1'b0, 4);
        add_row(enc_r(7'h70, 0, 6, 0, 19, `OPC_OP_FP), 19, 1'b0, 32'h7ffffffb, 1'b0, 4);
        add_row(enc_i(1, 0, 0, 20, `OPC_OP_IMM), 20, 1'b0, 32'h00000001, 1'b0, 5);
        add_row(enc_i(2, 0, 0, 21, `OPC_OP_IMM), 21, 1'b0, 32'h00000002, 1'b0, 5);
        add_row(enc_r(7'h00, 21, 20, 0, 22, `OPC_OP), 22, 1'b0, 32'h00000003, 1'b0, 5);
        add_row(enc_r(7'h00, 22, 22, 0, 23, `OPC_OP), 23, 1'b0, 32'h00000006, 1'b0, 5);
        add_row(enc_i(2047, 0, 0, 24, `OPC_OP_IMM), 24, 1'b0, 32'h000007ff, 1'b0, 5);
        add_row(enc_r(7'h00, 24, 23, 4, 25, `OPC_OP), 25, 1'b0, 32'h000007f9, 1'b0, 5);
        add_row(enc_i(85, 0, 0, 26, `OPC_OP_IMM), 26, 1'b0, 32'h00000055, 1'b0, 6);
        add_row(enc_r(7'h00, 1, 1, 0, 1, `OPC_OP_FP), 1, 1'b0, 32'h00000000, 1'b1, 6);
        // store and branch carry immediate bits where rd would be
        add_row(enc_r(7'h00, 1, 0, 2, 26, 7'h23), 26, 1'b0, 32'h00000000, 1'b1, 6);
        add_row(enc_r(7'h00, 2, 1, 0, 26, 7'h63), 26, 1'b0, 32'h00000000, 1'b1, 6);
        add_row(enc_r(7'h70, 0, 1, 0, 29, `OPC_OP_FP), 29, 1'b0, 32'h00000064, 1'b0, 6);
        // reads stay three issue slots behind the illegal ops
        add_row(enc_i(7, 0, 0, 27, `OPC_OP_IMM), 27, 1'b0, 32'h00000007, 1'b0, 6);
        add_row(enc_r(7'h00, 0, 26, 0, 28, `OPC_OP), 28, 1'b0, 32'h00000055, 1'b0, 6);
    endtask

    task automatic advance();
        @(negedge clk);
        if (in_credit) begin
            credits = credits + 1;
        end
    endtask

    task automatic drive_all();
        int i;
        int gap;
        credits = `FETCH_DEPTH;
        @(negedge reset);
        advance();
        for (i = 0; i < rows.size(); i++) begin
            // dependent and burst groups send as soon as a credit is there
            gap = (rows[i].group == 4'd4 || rows[i].group == 4'd5) ? 0
                  : int'((lcg_next() >> 16) % 32'd3);
            repeat (gap) advance();
            while (credits == 0) begin
                advance();
            end
            in_valid = 1'b1;
            in_instr = rows[i].instr;
            credits = credits - 1;
            advance();
            in_valid = 1'b0;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            errors = errors + 1;
            group_errors = group_errors + 1;
        end
    endtask

    task automatic report_group(input int g);
        if (group_errors == 0) begin
            groups_passed = groups_passed + 1;
            $display("group %0d (%s): ok", g, group_name(g));
        end else begin
            groups_failed = groups_failed + 1;
            $display("group %0d (%s): %0d mismatches", g, group_name(g), group_errors);
        end
        group_errors = 0;
    endtask

    task automatic watchdog();
        int limit;
        limit = rows.size() * 12 + 50;
        repeat (limit) @(posedge clk);
        $display("retirement stalled: %0d of %0d instructions retired within %0d cycles",
                 ret_idx, rows.size(), limit);
        $display("TEST FAILED");
        $finish;
    endtask

    // retire port is registered, so the falling edge sees it settled
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            if (ret_idx >= rows.size()) begin
                $display("an instruction retired at %0t after the whole table had retired",
                         $time);
                errors = errors + 1;
            end else begin
                check("retire_rd", 32'(retire_rd), 32'(rows[ret_idx].rd));
                check("retire_fp", 32'(retire_fp), 32'(rows[ret_idx].fp));
                check("retire_result", retire_result, rows[ret_idx].result);
                check("retire_illegal", 32'(retire_illegal), 32'(rows[ret_idx].illegal));
                if (ret_idx == rows.size() - 1
                    || rows[ret_idx + 1].group != rows[ret_idx].group) begin
                    report_group(int'(rows[ret_idx].group));
                end
                ret_idx = ret_idx + 1;
            end
        end
    end

    initial begin
        in_valid = 1'b0;
        in_instr = '0;
        build_table();
        fork
            watchdog();
        join_none
        drive_all();
        wait (ret_idx == rows.size());
        // a few more cycles to catch stray retirements
        repeat (4) @(negedge clk);
        $display("groups passed %0d, groups failed %0d, mismatches %0d",
                 groups_passed, groups_failed, errors);
        if (errors == 0 && groups_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

//--- tb/core_checker.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module core_checker (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_credit,
    input logic retire_valid
);
    // entries accepted but not yet handed back as credits
    logic [3:0] occupancy;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + {3'b0, in_valid} - {3'b0, in_credit};
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !in_credit) |-> (occupancy < 4'(`FETCH_DEPTH)))
        else $error("fetch buffer pushed past its depth");

    a_credit_has_entry: assert property (@(posedge clk) disable iff (reset)
        in_credit |-> (occupancy != '0))
        else $error("credit returned with no accepted entry");

    a_quiet_after_reset: assert property (@(posedge clk)
        $past(reset) |-> (!retire_valid && !in_credit))
        else $error("activity during reset");
endmodule

bind core_top core_checker u_core_checker (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_credit(in_credit),
    .retire_valid(retire_valid)
);

//--- tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic reset
);
    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // held for four rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end
endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps

module core_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  rv_pkg::word_t    in_instr,
    output logic             in_credit,
    output logic             retire_valid,
    output rv_pkg::reg_idx_t retire_rd,
    output logic             retire_fp,
    output rv_pkg::word_t    retire_result,
    output logic             retire_illegal
);
    logic head_valid;
    rv_pkg::word_t head_instr;
    logic take;
    rv_pkg::dec_ex_t dec_ex;
    rv_pkg::ex_wb_t ex_wb;

    fetch_buffer i_fetch_buffer (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .take(take),
        .head_valid(head_valid),
        .head_instr(head_instr),
        .in_credit(in_credit)
    );

    instr_decode i_instr_decode (
        .clk(clk),
        .reset(reset),
        .head_valid(head_valid),
        .head_instr(head_instr),
        .take(take),
        .ex_wb(ex_wb),
        .dec_ex(dec_ex)
    );

    execute i_execute (
        .clk(clk),
        .reset(reset),
        .dec_ex(dec_ex),
        .ex_wb(ex_wb)
    );

    // writeback stage shows up here as the retire port
    assign retire_valid = ex_wb.valid;
    assign retire_rd = ex_wb.rd;
    assign retire_fp = ex_wb.fp_write;
    assign retire_result = ex_wb.result;
    assign retire_illegal = ex_wb.illegal;
endmodule

//--- hw/execute.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module execute (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::dec_ex_t dec_ex,
    output rv_pkg::ex_wb_t  ex_wb
);
    localparam int SIGN = `XLEN - 1;

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rv_pkg::word_t result;

    assign op_a = dec_ex.rs1_val;
    assign op_b = dec_ex.ctrl.use_imm ? dec_ex.imm : dec_ex.rs2_val;

    always_comb begin
        case (dec_ex.ctrl.alu_op)
            rv_pkg::ALU_ADD: result = op_a + op_b;
            rv_pkg::ALU_SUB: result = op_a - op_b;
            rv_pkg::ALU_AND: result = op_a & op_b;
            rv_pkg::ALU_OR: result = op_a | op_b;
            rv_pkg::ALU_XOR: result = op_a ^ op_b;
            rv_pkg::ALU_SLT: result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pkg::ALU_LUI: result = dec_ex.imm;
            // raw bit copies between the files
            rv_pkg::ALU_FMV_W_X: result = op_a;
            rv_pkg::ALU_FMV_X_W: result = op_a;
            rv_pkg::ALU_FSGNJ: result = {op_b[SIGN], op_a[SIGN-1:0]};
            rv_pkg::ALU_FSGNJN: result = {~op_b[SIGN], op_a[SIGN-1:0]};
            rv_pkg::ALU_FSGNJX: result = {op_a[SIGN] ^ op_b[SIGN], op_a[SIGN-1:0]};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb.valid <= dec_ex.valid;
            ex_wb.rd <= dec_ex.rd;
            ex_wb.result <= dec_ex.ctrl.illegal ? '0 : result;
            // bubbles never write
            ex_wb.reg_write <= dec_ex.valid & dec_ex.ctrl.reg_write;
            ex_wb.fp_write <= dec_ex.valid & dec_ex.ctrl.fp_write;
            ex_wb.illegal <= dec_ex.ctrl.illegal;
        end
    end
endmodule

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module instr_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              head_valid,
    input  rv_pkg::word_t     head_instr,
    output logic              take,
    input  rv_pkg::ex_wb_t    ex_wb,
    output rv_pkg::dec_ex_t   dec_ex
);
    rv_pkg::ctrl_t ctrl;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t imm;
    rv_pkg::word_t int_rd1;
    rv_pkg::word_t int_rd2;
    rv_pkg::word_t fp_rd1;
    rv_pkg::word_t fp_rd2;
    logic rs1_used;
    logic rs2_used;
    logic hazard;

    assign rs1 = head_instr[19:15];
    assign rs2 = head_instr[24:20];
    assign rd = head_instr[11:7];
    assign imm = (ctrl.alu_op == rv_pkg::ALU_LUI) ? {head_instr[31:12], 12'b0}
                                                   : {{(`XLEN-12){head_instr[31]}},
                                                      head_instr[31:20]};

    control_unit i_control_unit (
        .instr(head_instr),
        .ctrl(ctrl)
    );

    int_regfile i_int_regfile (
        .clk(clk),
        .reset(reset),
        .we(ex_wb.reg_write),
        .waddr(ex_wb.rd),
        .wdata(ex_wb.result),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(int_rd1),
        .rdata2(int_rd2)
    );

    fp_regfile i_fp_regfile (
        .clk(clk),
        .reset(reset),
        .we(ex_wb.fp_write),
        .waddr(ex_wb.rd),
        .wdata(ex_wb.result),
        .raddr1(rs1),
        .raddr2(rs2),
        .rdata1(fp_rd1),
        .rdata2(fp_rd2)
    );

    // pending write to the same file and index
    function automatic logic src_hit(
        input rv_pkg::reg_idx_t idx,
        input logic             fp,
        input logic             valid,
        input rv_pkg::reg_idx_t wr_rd,
        input logic             int_we,
        input logic             fp_we
    );
        return valid && (wr_rd == idx) && (fp ? fp_we : (int_we && idx != '0));
    endfunction

    assign rs1_used = (ctrl.alu_op != rv_pkg::ALU_LUI);
    assign rs2_used = !ctrl.use_imm && (ctrl.alu_op != rv_pkg::ALU_FMV_W_X)
                      && (ctrl.alu_op != rv_pkg::ALU_FMV_X_W);

    assign hazard = !ctrl.illegal && (
        (rs1_used && (src_hit(rs1, ctrl.rs1_fp, dec_ex.valid, dec_ex.rd,
                              dec_ex.ctrl.reg_write, dec_ex.ctrl.fp_write)
                   || src_hit(rs1, ctrl.rs1_fp, ex_wb.valid, ex_wb.rd,
                              ex_wb.reg_write, ex_wb.fp_write)))
        || (rs2_used && (src_hit(rs2, ctrl.rs2_fp, dec_ex.valid, dec_ex.rd,
                                 dec_ex.ctrl.reg_write, dec_ex.ctrl.fp_write)
                      || src_hit(rs2, ctrl.rs2_fp, ex_wb.valid, ex_wb.rd,
                                 ex_wb.reg_write, ex_wb.fp_write))));

    assign take = head_valid && !hazard;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_ex.valid <= 1'b0;
        end else begin
            // stall leaves a bubble behind
            dec_ex.valid <= take;
            if (take) begin
                dec_ex.ctrl <= ctrl;
                dec_ex.rd <= rd;
                dec_ex.rs1_val <= ctrl.rs1_fp ? fp_rd1 : int_rd1;
                dec_ex.rs2_val <= ctrl.rs2_fp ? fp_rd2 : int_rd2;
                dec_ex.imm <= imm;
            end
        end
    end
endmodule

//--- hw/fp_regfile.sv
`timescale 1ns/1ps

module fp_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    // raw single precision bit patterns
    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];
endmodule

//--- hw/int_regfile.sv
`timescale 1ns/1ps

module int_regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    input  rv_pkg::reg_idx_t raddr1,
    input  rv_pkg::reg_idx_t raddr2,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

//--- hw/control_unit.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module control_unit (
    input  rv_pkg::word_t instr,
    output rv_pkg::ctrl_t ctrl
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] funct5;
    logic [1:0] fmt;
    logic [4:0] rs2_field;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct5 = instr[31:27];
    assign fmt = instr[26:25];
    assign rs2_field = instr[24:20];

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = rv_pkg::ALU_ADD;
        ctrl.illegal = 1'b1;
        case (opcode)
            `OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.illegal = 1'b0;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = rv_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = rv_pkg::ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = rv_pkg::ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = rv_pkg::ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = rv_pkg::ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = rv_pkg::ALU_SLT;
                    default: begin
                        ctrl.reg_write = 1'b0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            `OPC_OP_IMM: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.illegal = 1'b0;
                case (funct3)
                    3'b000: ctrl.alu_op = rv_pkg::ALU_ADD;
                    3'b111: ctrl.alu_op = rv_pkg::ALU_AND;
                    3'b110: ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b100: ctrl.alu_op = rv_pkg::ALU_XOR;
                    default: begin
                        ctrl.use_imm = 1'b0;
                        ctrl.reg_write = 1'b0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            `OPC_LUI: begin
                ctrl.alu_op = rv_pkg::ALU_LUI;
                ctrl.use_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.illegal = 1'b0;
            end
            `OPC_OP_FP: begin
                // single precision only
                if (fmt == 2'b00) begin
                    if (funct5 == `FUNCT5_FSGNJ && funct3 <= 3'b010) begin
                        ctrl.alu_op = (funct3 == 3'b000) ? rv_pkg::ALU_FSGNJ :
                                      (funct3 == 3'b001) ? rv_pkg::ALU_FSGNJN :
                                                           rv_pkg::ALU_FSGNJX;
                        ctrl.rs1_fp = 1'b1;
                        ctrl.rs2_fp = 1'b1;
                        ctrl.fp_write = 1'b1;
                        ctrl.illegal = 1'b0;
                    end else if (funct5 == `FUNCT5_FMV_X_W && funct3 == 3'b000
                                 && rs2_field == 5'd0) begin
                        ctrl.alu_op = rv_pkg::ALU_FMV_X_W;
                        ctrl.rs1_fp = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.illegal = 1'b0;
                    end else if (funct5 == `FUNCT5_FMV_W_X && funct3 == 3'b000
                                 && rs2_field == 5'd0) begin
                        ctrl.alu_op = rv_pkg::ALU_FMV_W_X;
                        ctrl.fp_write = 1'b1;
                        ctrl.illegal = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    end
endmodule

//--- hw/fetch_buffer.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module fetch_buffer (
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  rv_pkg::word_t in_instr,
    input  logic          take,
    output logic          head_valid,
    output rv_pkg::word_t head_instr,
    output logic          in_credit
);
    localparam int PTR_W = $clog2(`FETCH_DEPTH);
    localparam int CNT_W = $clog2(`FETCH_DEPTH + 1);

    rv_pkg::word_t mem [`FETCH_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic pop;

    assign pop = take & head_valid;
    assign head_valid = (count != '0);
    assign head_instr = mem[rd_ptr];
    // one credit back per slot freed
    assign in_credit = pop;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(`FETCH_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`FETCH_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end
endmodule

//--- hw/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_FMV_W_X,
        ALU_FMV_X_W,
        ALU_FSGNJ,
        ALU_FSGNJN,
        ALU_FSGNJX
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    fp_write;
        logic    rs1_fp;
        logic    rs2_fp;
        logic    illegal;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
    } dec_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    result;
        logic     reg_write;
        logic     fp_write;
        logic     illegal;
    } ex_wb_t;

endpackage

//--- hw/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define FETCH_DEPTH 4

// major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_OP_FP   7'b1010011

`define FUNCT5_FSGNJ   5'b00100
`define FUNCT5_FMV_X_W 5'b11100
`define FUNCT5_FMV_W_X 5'b11110

`endif
